/* Makefile */
# Verilator build and run of the main board bus testbench
VERILATOR ?= verilator
TOP       ?= tb_snowbro2
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the simulator printed the pass line
test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/snowbro2_props.sv */
// bus handshake and gp9001 strobe assertions, bound into the main bus top level
`timescale 1ns/1ns
`default_nettype none

module snowbro2_props (
    input wire                             CLK96,
    input wire                             RESET96,
    input wire                             as_n,
    input wire                             dtack_n,
    input wire snowbro2_pkg::cycle_state_t state,
    input wire [5:0]                       strobes
);
    import snowbro2_pkg::*;

    // cpu ends the cycle by raising as_n
    dtack_release: assert property (@(posedge CLK96) disable iff (RESET96)
        $rose(as_n) |-> ##[0:1] dtack_n)
        else $error("dtack_n still low one cycle after as_n rose");

    strobe_onehot: assert property (@(posedge CLK96) disable iff (RESET96)
        $onehot0(strobes))
        else $error("more than one gp9001 strobe high");

    idle_no_dtack: assert property (@(posedge CLK96) disable iff (RESET96)
        (state == CYC_IDLE) |-> dtack_n)
        else $error("dtack_n low while the cycle controller is idle");

endmodule

bind snowbro2_main_bus snowbro2_props u_props (
    .CLK96   (CLK96),
    .RESET96 (RESET96),
    .as_n    (as_n),
    .dtack_n (dtack_n),
    .state   (u_cycle.state),
    .strobes ({gp_set_ram_ptr, gp_write_ram, gp_read_ram_h,
               gp_read_ram_l, gp_select_reg, gp_write_reg})
);

`default_nettype wire

/* dv/tb_snowbro2.sv */
// directed testbench for the main board bus, plays the 68000 and a simple gp9001
`timescale 1ns/1ns
`default_nettype none

module tb_snowbro2;
    import snowbro2_pkg::*;

    localparam int DTACK_LIMIT = 64;
    localparam int RUN_LIMIT   = 6 * 40 * 70 * 20;    // tests x cycles x clocks x ns

    logic CLK96, RESET96, cpu_rw, uds_n, lds_n, as_n, dtack_n;
    bus_addr_t cpu_addr;
    word_t cpu_wdata, cpu_din, gp9001_dout, pal_data;
    logic [9:0] joystick1, joystick2, joystick3, joystick4;
    logic [3:0] start_button, coin_input;
    logic service, dip_test, hsync, vsync, fblank, gp9001_ack;
    byte_t dipsw_a, dipsw_b, dipsw_c, ym_dout, oki_dout, snd_din;
    logic [8:0] vcount;
    logic [10:0] pal_addr;
    logic gp_set_ram_ptr, gp_write_ram, gp_read_ram_h, gp_read_ram_l, gp_select_reg;
    logic gp_write_reg, ym_cs, ym_a0, ym_we_n, oki_cs, oki_we_n, oki_bank;
    logic [5:0] gp_strobes, strobe_at_ack;
    logic [12:0] snd_snap;    // sound pins seen during the last access
    logic ack_before;
    logic [31:0] lfsr = 32'h77de_a909;
    int errors = 0, checks = 0, last_edges = 0, ack_count = 0, gp_delay = 1;

    snowbro2_main_bus uut (.*);

    assign gp_strobes = {gp_set_ram_ptr, gp_write_ram, gp_read_ram_h,
                         gp_read_ram_l, gp_select_reg, gp_write_reg};

    initial begin
        CLK96 = 1'b0;
        forever #10 CLK96 = ~CLK96;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
        end
        return r;
    endfunction

    function automatic byte_t player_exp(input logic [9:0] joy, input logic p34);
        byte_t b;
        b = 8'h00;
        b[6] = p34 ? !joy[6] : 1'b0;    // third button only on players 3 and 4
        b[5:4] = ~joy[5:4];
        b[3:0] = ~{joy[0], joy[1], joy[2], joy[3]};
        return b;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        $display("%-12s done, %0d errors", name, errors - start);
    endtask

    task automatic step();
        @(posedge CLK96);
        #2;
    endtask

    // one 68000 cycle, ds_n is {uds_n, lds_n}
    task automatic bus_access(input logic [23:0] a, input logic rd, input logic [1:0] ds_n,
                              input word_t wd, output word_t q);
        int n;
        int acks;
        step();
        cpu_addr  = a[23:1];
        cpu_wdata = wd;
        cpu_rw    = rd;
        {uds_n, lds_n} = ds_n;
        as_n      = 1'b0;
        snd_snap  = '0;
        acks      = ack_count;
        n = 0;
        while (dtack_n && n < DTACK_LIMIT) begin
            @(posedge CLK96);
            #1;
            n++;
            if (ym_cs || oki_cs) begin
                snd_snap = {ym_cs, ym_a0, ym_we_n, oki_cs, oki_we_n, snd_din};
            end
        end
        last_edges = n;
        ack_before = ack_count != acks;
        q = cpu_din;
        if (dtack_n) begin
            $display("no dtack_n within %0d cycles for address %h", DTACK_LIMIT, a);
            errors++;
        end
        #1;
        as_n   = 1'b1;
        uds_n  = 1'b1;
        lds_n  = 1'b1;
        cpu_rw = 1'b1;
        @(posedge CLK96);
        #1;
        if (!dtack_n) begin
            $display("dtack_n did not rise after as_n at %0t ns", $time);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [23:0] a, input logic [1:0] ds_n, input word_t wd);
        word_t unused_q;
        bus_access(a, 1'b0, ds_n, wd, unused_q);
    endtask

    task automatic bus_read(input logic [23:0] a, output word_t q);
        bus_access(a, 1'b1, 2'b00, 16'h0000, q);
    endtask

    task automatic test_wram();
        int start;
        logic [23:0] a;
        word_t w1, w2, q, exp_w;
        start = errors;
        for (int i = 0; i < 8; i++) begin
            a  = 24'h100000 | {8'h00, 15'(rand_bits(15)), 1'b0};
            w1 = 16'(rand_bits(16));
            w2 = 16'(rand_bits(16));
            bus_write(a, 2'b00, w1);
            bus_write(a, i[0] ? 2'b01 : 2'b10, w2);    // one lane only
            exp_w = i[0] ? {w2[15:8], w1[7:0]} : {w1[15:8], w2[7:0]};
            bus_read(a, q);
            check_word("wram cpu_din", q, exp_w);
            // sampling edge, the idle exit, then the wait count
            check_word("wram dtack edges", 16'(last_edges), 16'(LOCAL_WAIT + 2));
        end
        report_test("work ram", start);
    endtask

    task automatic test_palram();
        int start;
        logic [10:0] idx;
        word_t w, q;
        start = errors;
        for (int i = 0; i < 4; i++) begin
            idx = 11'(rand_bits(11));
            w   = 16'(rand_bits(16));
            bus_write({12'h400, idx, 1'b0}, 2'b00, w);
            step();
            pal_addr = idx;
            @(posedge CLK96);
            #1;
            check_word("pal_data", pal_data, w);
            bus_read({12'h400, idx, 1'b0}, q);
            check_word("palram cpu_din", q, w);
        end
        report_test("palette ram", start);
    endtask

    task automatic io_check(input string name, input logic [11:0] off, input word_t exp);
        word_t q;
        bus_read({12'h700, off}, q);
        check_word(name, q, exp);
    endtask

    task automatic test_io();
        int start;
        byte_t sys_lo;
        start = errors;
        step();
        joystick1 = 10'(rand_bits(10));
        joystick2 = 10'(rand_bits(10));
        joystick3 = 10'(rand_bits(10));
        joystick4 = 10'(rand_bits(10));
        start_button = 4'(rand_bits(4));
        coin_input   = 4'(rand_bits(4));
        service  = 1'(rand_bits(1));
        dip_test = 1'(rand_bits(1));
        dipsw_a  = 8'(rand_bits(8));
        dipsw_b  = 8'(rand_bits(8));
        dipsw_c  = 8'(rand_bits(8));
        {hsync, vsync, fblank} = 3'b100;    // hsync only
        vcount = 9'h0A5;
        io_check("in1", IO_IN1, {2{player_exp(joystick1, 1'b0)}});
        io_check("in2", IO_IN2, {2{player_exp(joystick2, 1'b0)}});
        io_check("in3", IO_IN3, {2{player_exp(joystick3, 1'b1)}});
        io_check("in4", IO_IN4, {2{player_exp(joystick4, 1'b1)}});
        io_check("dswa", IO_DSWA, {2{dipsw_a}});
        io_check("dswb", IO_DSWB, {2{dipsw_b}});
        io_check("jumper", IO_JMPR, {2{dipsw_c}});
        sys_lo = {1'b0, ~start_button[1:0], ~coin_input[1:0], ~dip_test, 1'b0, ~service};
        io_check("system", IO_SYS, {dipsw_c, sys_lo});
        io_check("vstat", IO_VSTAT, {8'hBE, 8'hA5});
        step();
        vcount = 9'h1F0;    // past line 255
        io_check("vstat high line", IO_VSTAT, {8'hBE, 8'hFF});
        report_test("io reads", start);
    endtask

    task automatic gp_check(input string name, input logic [23:0] a, input logic rd,
                            input logic [5:0] exp_strobe);
        word_t q, d;
        d = 16'(rand_bits(16));
        gp_delay = 1 + int'(rand_bits(3));
        step();
        gp9001_dout = d;
        if (rd) begin
            bus_read(a, q);
            check_word({name, " cpu_din"}, q, d);
        end else begin
            bus_write(a, 2'b00, d);
        end
        check_word({name, " strobe"}, 16'(strobe_at_ack), 16'(exp_strobe));
        checks++;
        if (!ack_before) begin
            $display("%s: dtack_n fell before gp9001_ack", name);
            errors++;
        end
    endtask

    task automatic test_gp9001();
        int start;
        start = errors;
        gp_check("gp read h", 24'h300004, 1'b1, 6'b001000);
        gp_check("gp read l", 24'h300006, 1'b1, 6'b000100);
        gp_check("gp ram ptr", 24'h300000, 1'b0, 6'b100000);
        gp_check("gp write h", 24'h300004, 1'b0, 6'b010000);
        gp_check("gp write l", 24'h300006, 1'b0, 6'b010000);
        gp_check("gp sel reg", 24'h300008, 1'b0, 6'b000010);
        gp_check("gp wr reg", 24'h30000C, 1'b0, 6'b000001);
        report_test("gp9001", start);
    endtask

    task automatic test_sound();
        int start;
        logic a0;
        word_t d, q;
        start = errors;
        step();
        ym_dout  = 8'(rand_bits(8));
        oki_dout = 8'(rand_bits(8));
        for (int k = 0; k < 2; k++) begin
            a0 = k[0];
            d  = 16'(rand_bits(16));
            bus_write({16'h5000, 6'h00, a0, 1'b0}, 2'b00, d);
            check_word("ym pins", 16'(snd_snap), 16'({1'b1, a0, 3'b001, d[7:0]}));
        end
        d = 16'(rand_bits(16));
        bus_write(24'h600000, 2'b00, d);
        check_word("oki pins", 16'(snd_snap), 16'({1'b0, 1'b0, 3'b110, d[7:0]}));
        bus_read(24'h500000, q);
        check_word("ym read", q, {2{ym_dout}});
        bus_read(24'h600000, q);
        check_word("oki read", q, {2{oki_dout}});
        bus_write({12'h700, IO_OKIBANK}, 2'b10, 16'h0001);
        check_word("oki_bank", 16'(oki_bank), 16'h0001);
        bus_write({12'h700, IO_OKIBANK}, 2'b01, 16'h0000);    // upper lane, no effect
        check_word("oki_bank upper lane", 16'(oki_bank), 16'h0001);
        report_test("sound", start);
    endtask

    task automatic test_reset_unmapped();
        int start;
        word_t q;
        start = errors;
        step();
        RESET96 = 1'b1;
        repeat (10) @(posedge CLK96);
        #2;
        RESET96 = 1'b0;
        #1;
        check_word("reset pins", 16'({dtack_n, gp_strobes, oki_bank, ym_cs, oki_cs, oki_we_n}),
                   16'(11'b100_0000_0001));
        check_word("reset cpu_din", cpu_din, 16'h0000);
        bus_read({12'h700, IO_VSTAT}, q);    // leaves a non-zero word on cpu_din
        check_word("vstat after reset", q, 16'hBEFF);
        bus_read(24'h800000, q);
        check_word("unmapped cpu_din", q, 16'h0000);
        check_word("unmapped dtack edges", 16'(last_edges), 16'(LOCAL_WAIT + 2));
        report_test("reset/unmap", start);
    endtask

    // gp9001 stand-in, one-cycle ack after the delay the test chose
    initial begin
        gp9001_ack = 1'b0;
        strobe_at_ack = '0;
        forever begin
            @(posedge CLK96);
            #1;
            if (gp_strobes != '0) begin
                repeat (gp_delay) @(posedge CLK96);
                #2;
                strobe_at_ack = gp_strobes;
                ack_count++;
                gp9001_ack = 1'b1;
                @(posedge CLK96);
                #2;
                gp9001_ack = 1'b0;
            end
        end
    end

    initial begin
        #(RUN_LIMIT);
        $display("watchdog expired after %0d ns, the bus is hung", RUN_LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin
        RESET96 = 1'b1;
        cpu_addr = '0;
        cpu_wdata = '0;
        {cpu_rw, uds_n, lds_n, as_n} = 4'b1111;
        {joystick1, joystick2, joystick3, joystick4} = '0;
        {start_button, coin_input, service, dip_test} = '0;
        {dipsw_a, dipsw_b, dipsw_c, ym_dout, oki_dout} = '0;
        {hsync, vsync, fblank, vcount} = '0;
        gp9001_dout = '0;
        pal_addr = '0;
        repeat (10) @(posedge CLK96);
        #2;
        RESET96 = 1'b0;
        test_wram();
        test_palram();
        test_io();
        test_gp9001();
        test_sound();
        test_reset_unmapped();
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/bus_cycle.sv */
// bus cycle controller, counts wait states or waits for the gp9001, drives dtack and read data
`timescale 1ns/1ns
`default_nettype none

module bus_cycle #(
    parameter int WAIT_STATES = 2
) (
    input  wire                            CLK96,
    input  wire                            RESET96,
    cpu_bus_if.device                      bus,
    input  wire snowbro2_pkg::region_sel_t region,
    input  wire                            gp9001_ack,
    input  wire snowbro2_pkg::word_t       wram_q,
    input  wire snowbro2_pkg::word_t       palram_q,
    input  wire snowbro2_pkg::word_t       gp9001_dout,
    input  wire snowbro2_pkg::word_t       io_rdata,
    output snowbro2_pkg::word_t            cpu_din,
    output logic                           dtack_n
);
    import snowbro2_pkg::*;

    localparam int CNT_W = $clog2(WAIT_STATES + 1);

    cycle_state_t     state;
    logic [CNT_W-1:0] wait_cnt;
    logic             done;
    word_t            rd_word;

    // gp9001 has variable latency, the rest a fixed count
    assign done = region[REG_GP9001] ? gp9001_ack : (wait_cnt == '0);

    always_comb begin
        rd_word = '0;    // writes and unmapped reads
        if (bus.rw) begin
            if (region[REG_WRAM]) begin
                rd_word = wram_q;
            end else if (region[REG_PALRAM]) begin
                rd_word = palram_q;
            end else if (region[REG_GP9001]) begin
                rd_word = gp9001_dout;
            end else if (region[REG_IO] || region[REG_YM] || region[REG_OKI]) begin
                rd_word = io_rdata;
            end
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state    <= CYC_IDLE;
            wait_cnt <= '0;
            dtack_n  <= 1'b1;
            cpu_din  <= '0;
        end else begin
            case (state)
                CYC_IDLE: begin
                    wait_cnt <= CNT_W'(WAIT_STATES - 1);
                    if (|region) begin
                        state <= CYC_WAIT;
                    end
                end
                CYC_WAIT: begin
                    if (done) begin
                        state   <= CYC_ACK;
                        dtack_n <= 1'b0;
                        cpu_din <= rd_word;    // held until the next cycle
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                CYC_ACK, CYC_END: begin
                    if (bus.as_n) begin    // cpu has taken the data
                        state   <= CYC_IDLE;
                        dtack_n <= 1'b1;
                    end else begin
                        state <= CYC_END;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/bus_decode.sv */
// registered address decode, turns the cpu address into a one-hot region select
`timescale 1ns/1ns
`default_nettype none

module bus_decode (
    input  wire                       CLK96,
    input  wire                       RESET96,
    cpu_bus_if.device                 bus,
    output snowbro2_pkg::region_sel_t region
);
    import snowbro2_pkg::*;

    region_sel_t hit;

    // pages are disjoint, so at most one bit besides none
    always_comb begin
        hit = '0;
        hit[REG_WRAM]   = bus.addr[23:16] == WRAM_PAGE;
        hit[REG_GP9001] = bus.addr[23:20] == GP9001_PAGE;
        hit[REG_PALRAM] = bus.addr[23:20] == PALRAM_PAGE;
        hit[REG_IO]     = bus.addr[23:12] == IO_PAGE;
        hit[REG_YM]     = bus.addr[23:8] == YM_PAGE;
        hit[REG_OKI]    = bus.addr[23:8] == OKI_PAGE;
        hit[REG_NONE]   = hit == '0;    // nothing matched
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            region <= '0;
        end else if (!bus.as_n) begin
            region <= hit;
        end else begin
            region <= '0;    // bus idle between cycles
        end
    end

endmodule

`default_nettype wire

/* hw/byte_ram.sv */
// dual-port word ram, byte-lane writes from the cpu and a read-only second port
`timescale 1ns/1ns
`default_nettype none

module byte_ram #(
    parameter int ADDR_W = 11
) (
    input  wire                CLK96,
    cpu_bus_if.device          bus,
    input  wire                sel,
    output snowbro2_pkg::word_t q,
    input  wire [ADDR_W-1:0]   rd_addr,
    output snowbro2_pkg::word_t rd_data
);
    import snowbro2_pkg::*;

    word_t             mem [2**ADDR_W];
    logic [ADDR_W-1:0] cpu_idx;
    logic              wr;

    assign cpu_idx = bus.addr[ADDR_W:1];
    assign wr      = sel && !bus.rw;    // rewritten every cycle of the access

    always_ff @(posedge CLK96) begin
        if (wr && !bus.uds_n) begin
            mem[cpu_idx][15:8] <= bus.wdata[15:8];
        end
        if (wr && !bus.lds_n) begin
            mem[cpu_idx][7:0] <= bus.wdata[7:0];
        end
        q       <= mem[cpu_idx];
        rd_data <= mem[rd_addr];    // video side, one cycle latency
    end

endmodule

`default_nettype wire

/* hw/cpu_bus_if.sv */
// cpu bus bundle, driven by the top level and read by every bus device
`timescale 1ns/1ns
`default_nettype none

interface cpu_bus_if;
    import snowbro2_pkg::*;

    bus_addr_t addr;
    word_t     wdata;
    logic      rw;       // high on reads
    logic      uds_n;
    logic      lds_n;
    logic      as_n;

    modport host (output addr, wdata, rw, uds_n, lds_n, as_n);

    modport device (input addr, wdata, rw, uds_n, lds_n, as_n);

endinterface

`default_nettype wire

/* hw/gp9001_cmd.sv */
// gp9001 command strobes, one per access, held until the controller acknowledges
`timescale 1ns/1ns
`default_nettype none

module gp9001_cmd (
    input  wire                            CLK96,
    input  wire                            RESET96,
    cpu_bus_if.device                      bus,
    input  wire snowbro2_pkg::region_sel_t region,
    input  wire                            gp9001_ack,
    output logic                           gp_set_ram_ptr,
    output logic                           gp_write_ram,
    output logic                           gp_read_ram_h,
    output logic                           gp_read_ram_l,
    output logic                           gp_select_reg,
    output logic                           gp_write_reg
);
    import snowbro2_pkg::*;

    logic       gp_seen;    // region seen on the previous edge
    logic       first;
    logic [3:0] offset;

    assign first  = region[REG_GP9001] && !gp_seen;
    assign offset = {bus.addr[3:1], 1'b0};

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            gp_seen        <= 1'b0;
            gp_set_ram_ptr <= 1'b0;
            gp_write_ram   <= 1'b0;
            gp_read_ram_h  <= 1'b0;
            gp_read_ram_l  <= 1'b0;
            gp_select_reg  <= 1'b0;
            gp_write_reg   <= 1'b0;
        end else begin
            gp_seen <= region[REG_GP9001];
            if (first && bus.rw) begin
                case (offset)
                    GP_RAM_H: gp_read_ram_h <= 1'b1;
                    GP_RAM_L: gp_read_ram_l <= 1'b1;
                    default: ;
                endcase
            end else if (first) begin
                case (offset)
                    GP_WR_REG:          gp_write_reg   <= 1'b1;
                    GP_SEL_REG:         gp_select_reg  <= 1'b1;
                    GP_RAM_H, GP_RAM_L: gp_write_ram   <= 1'b1;    // either half
                    GP_RAM_PTR:         gp_set_ram_ptr <= 1'b1;
                    default: ;
                endcase
            end else if (gp9001_ack) begin
                gp_set_ram_ptr <= 1'b0;
                gp_write_ram   <= 1'b0;
                gp_read_ram_h  <= 1'b0;
                gp_read_ram_l  <= 1'b0;
                gp_select_reg  <= 1'b0;
                gp_write_reg   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/io_ports.sv */
// cabinet inputs, video status, sound chip strobes and oki bank latch
`timescale 1ns/1ns
`default_nettype none

module io_ports (
    input  wire                            CLK96,
    input  wire                            RESET96,
    cpu_bus_if.device                      bus,
    input  wire snowbro2_pkg::region_sel_t region,
    input  wire [9:0]                      joystick1,
    input  wire [9:0]                      joystick2,
    input  wire [9:0]                      joystick3,
    input  wire [9:0]                      joystick4,
    input  wire [3:0]                      start_button,
    input  wire [3:0]                      coin_input,
    input  wire                            service,
    input  wire                            dip_test,
    input  wire snowbro2_pkg::byte_t       dipsw_a,
    input  wire snowbro2_pkg::byte_t       dipsw_b,
    input  wire snowbro2_pkg::byte_t       dipsw_c,
    input  wire                            hsync,
    input  wire                            vsync,
    input  wire                            fblank,
    input  wire [8:0]                      vcount,
    input  wire snowbro2_pkg::byte_t       ym_dout,
    input  wire snowbro2_pkg::byte_t       oki_dout,
    output snowbro2_pkg::word_t            io_rdata,
    output logic                           ym_cs,
    output logic                           ym_a0,
    output logic                           ym_we_n,
    output logic                           oki_cs,
    output logic                           oki_we_n,
    output logic                           oki_bank,
    output snowbro2_pkg::byte_t            snd_din
);
    import snowbro2_pkg::*;

    logic [11:0] offset;
    byte_t       vline;

    // inputs are active high here, the board reads them inverted
    function automatic byte_t player_byte(input logic [9:0] joy, input logic has_b3);
        return {1'b0, has_b3 & ~joy[6], ~joy[5], ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    assign offset = {bus.addr[11:1], 1'b0};
    assign vline  = vcount[8] ? 8'hFF : vcount[7:0];    // saturates past line 255

    always_comb begin
        io_rdata = '0;
        if (region[REG_IO] && bus.rw) begin
            case (offset)
                IO_JMPR:  io_rdata = {2{dipsw_c}};
                IO_DSWA:  io_rdata = {2{dipsw_a}};
                IO_DSWB:  io_rdata = {2{dipsw_b}};
                IO_IN1:   io_rdata = {2{player_byte(joystick1, 1'b0)}};
                IO_IN2:   io_rdata = {2{player_byte(joystick2, 1'b0)}};
                IO_IN3:   io_rdata = {2{player_byte(joystick3, 1'b1)}};
                IO_IN4:   io_rdata = {2{player_byte(joystick4, 1'b1)}};
                IO_SYS:   io_rdata = {dipsw_c, 1'b0, ~start_button[1], ~start_button[0],
                                      ~coin_input[1], ~coin_input[0], ~dip_test, 1'b0, ~service};
                IO_VSTAT: io_rdata = {hsync, vsync, 5'b11111, fblank, vline};
                default:  io_rdata = '0;
            endcase
        end else if (region[REG_YM] && bus.rw) begin
            io_rdata = {2{ym_dout}};
        end else if (region[REG_OKI] && bus.rw) begin
            io_rdata = {2{oki_dout}};
        end
    end

    assign ym_cs    = region[REG_YM];
    assign oki_cs   = region[REG_OKI];
    assign ym_a0    = bus.addr[1];    // register select vs data
    assign ym_we_n  = ~(ym_cs & ~bus.rw);
    assign oki_we_n = ~(oki_cs & ~bus.rw);
    assign snd_din  = bus.wdata[7:0];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            oki_bank <= 1'b0;
        end else if (region[REG_IO] && !bus.rw && !bus.lds_n && offset == IO_OKIBANK) begin
            oki_bank <= bus.wdata[0];
        end
    end

endmodule

`default_nettype wire

/* hw/snowbro2_main_bus.sv */
// main board bus logic, connects the 68000 bus to memories, i/o, sound and the gp9001
`timescale 1ns/1ns
`default_nettype none

module snowbro2_main_bus #(
    parameter int WRAM_ADDR_W   = snowbro2_pkg::WRAM_ADDR_W,
    parameter int PALRAM_ADDR_W = snowbro2_pkg::PALRAM_ADDR_W,
    parameter int LOCAL_WAIT    = snowbro2_pkg::LOCAL_WAIT
) (
    input  wire                          CLK96,
    input  wire                          RESET96,
    input  wire snowbro2_pkg::bus_addr_t cpu_addr,
    input  wire snowbro2_pkg::word_t     cpu_wdata,
    input  wire                          cpu_rw,
    input  wire                          uds_n,
    input  wire                          lds_n,
    input  wire                          as_n,
    output snowbro2_pkg::word_t          cpu_din,
    output logic                         dtack_n,
    input  wire [9:0]                    joystick1,
    input  wire [9:0]                    joystick2,
    input  wire [9:0]                    joystick3,
    input  wire [9:0]                    joystick4,
    input  wire [3:0]                    start_button,
    input  wire [3:0]                    coin_input,
    input  wire                          service,
    input  wire                          dip_test,
    input  wire snowbro2_pkg::byte_t     dipsw_a,
    input  wire snowbro2_pkg::byte_t     dipsw_b,
    input  wire snowbro2_pkg::byte_t     dipsw_c,
    input  wire                          hsync,
    input  wire                          vsync,
    input  wire                          fblank,
    input  wire [8:0]                    vcount,
    input  wire                          gp9001_ack,
    input  wire snowbro2_pkg::word_t     gp9001_dout,
    output logic                         gp_set_ram_ptr,
    output logic                         gp_write_ram,
    output logic                         gp_read_ram_h,
    output logic                         gp_read_ram_l,
    output logic                         gp_select_reg,
    output logic                         gp_write_reg,
    input  wire [PALRAM_ADDR_W-1:0]      pal_addr,
    output snowbro2_pkg::word_t          pal_data,
    input  wire snowbro2_pkg::byte_t     ym_dout,
    input  wire snowbro2_pkg::byte_t     oki_dout,
    output logic                         ym_cs,
    output logic                         ym_a0,
    output logic                         ym_we_n,
    output logic                         oki_cs,
    output logic                         oki_we_n,
    output logic                         oki_bank,
    output snowbro2_pkg::byte_t          snd_din
);
    import snowbro2_pkg::*;

    cpu_bus_if   bus ();
    region_sel_t region;
    word_t       wram_q;
    word_t       palram_q;
    word_t       io_rdata;

    assign bus.addr  = cpu_addr;
    assign bus.wdata = cpu_wdata;
    assign bus.rw    = cpu_rw;
    assign bus.uds_n = uds_n;
    assign bus.lds_n = lds_n;
    assign bus.as_n  = as_n;

    bus_decode u_decode (.*);

    // work ram 0x100000, video port unused
    byte_ram #(.ADDR_W(WRAM_ADDR_W)) u_wram (
        .CLK96   (CLK96),
        .bus     (bus),
        .sel     (region[REG_WRAM]),
        .q       (wram_q),
        .rd_addr ('0),
        .rd_data ()
    );

    byte_ram #(.ADDR_W(PALRAM_ADDR_W)) u_palram (
        .CLK96   (CLK96),
        .bus     (bus),
        .sel     (region[REG_PALRAM]),
        .q       (palram_q),
        .rd_addr (pal_addr),
        .rd_data (pal_data)
    );

    io_ports u_io (.*);

    gp9001_cmd u_gp9001 (.*);

    bus_cycle #(.WAIT_STATES(LOCAL_WAIT)) u_cycle (.*);

endmodule

`default_nettype wire

/* hw/snowbro2_pkg.sv */
// bus types, region indices and memory map of the main board, imported by every bus block
`default_nettype none

package snowbro2_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [23:1] bus_addr_t;    // 68000 word address

    // one-hot region select, one bit per peer
    typedef logic [6:0] region_sel_t;

    localparam int REG_WRAM   = 0;
    localparam int REG_PALRAM = 1;
    localparam int REG_GP9001 = 2;
    localparam int REG_IO     = 3;
    localparam int REG_YM     = 4;
    localparam int REG_OKI    = 5;
    localparam int REG_NONE   = 6;     // unmapped, still acknowledged

    localparam logic [7:0]  WRAM_PAGE   = 8'h10;      // 0x10xxxx
    localparam logic [3:0]  GP9001_PAGE = 4'h3;       // 0x3xxxxx
    localparam logic [3:0]  PALRAM_PAGE = 4'h4;       // 0x4xxxxx
    localparam logic [11:0] IO_PAGE     = 12'h700;    // 0x700xxx
    localparam logic [15:0] YM_PAGE     = 16'h5000;
    localparam logic [15:0] OKI_PAGE    = 16'h6000;

    // byte offsets inside the i/o page
    localparam logic [11:0] IO_JMPR    = 12'h000;
    localparam logic [11:0] IO_DSWA    = 12'h004;
    localparam logic [11:0] IO_DSWB    = 12'h008;
    localparam logic [11:0] IO_IN1     = 12'h00C;
    localparam logic [11:0] IO_IN2     = 12'h010;
    localparam logic [11:0] IO_IN3     = 12'h014;
    localparam logic [11:0] IO_IN4     = 12'h018;
    localparam logic [11:0] IO_SYS     = 12'h01C;
    localparam logic [11:0] IO_VSTAT   = 12'h020;
    localparam logic [11:0] IO_OKIBANK = 12'h030;
    localparam logic [11:0] IO_COIN    = 12'h034;

    // gp9001 register offsets
    localparam logic [3:0] GP_RAM_PTR = 4'h0;
    localparam logic [3:0] GP_RAM_H   = 4'h4;
    localparam logic [3:0] GP_RAM_L   = 4'h6;
    localparam logic [3:0] GP_SEL_REG = 4'h8;
    localparam logic [3:0] GP_WR_REG  = 4'hC;

    localparam int WRAM_ADDR_W   = 15;
    localparam int PALRAM_ADDR_W = 11;
    localparam int LOCAL_WAIT    = 2;     // wait states for local devices

    typedef enum logic [1:0] {CYC_IDLE, CYC_WAIT, CYC_ACK, CYC_END} cycle_state_t;

endpackage

`default_nettype wire

/* src.f */
hw/snowbro2_pkg.sv
hw/cpu_bus_if.sv
hw/bus_decode.sv
hw/bus_cycle.sv
hw/byte_ram.sv
hw/io_ports.sv
hw/gp9001_cmd.sv
hw/snowbro2_main_bus.sv
dv/snowbro2_props.sv
dv/tb_snowbro2.sv
